// ==== logic/neoVideoPkg.sv ====
package neoVideoPkg;

	// Pixel bus shared by sprite attributes and fix palette
	localparam int pBusWidth = 24;

	// Line buffer entry holds an 8-bit sprite palette over a 4-bit colour
	localparam int lbWord = 12;

	// All ones after read-out
	// Gives the backdrop palette address when nothing was drawn
	localparam logic [lbWord-1:0] lbCleared = '1;

	// One bus word read as sprite attributes or as fix palette
	// attrLoad uses the sprite view and fixLoad the fix view
	typedef union packed {
		struct packed {
			logic [7:0] sprPal;       // Sprite palette in the top byte
			logic [7:0] sprX;         // Sprite X position
			logic [7:0] sprUnused;
		} spr;
		struct packed {
			logic [3:0]  fixUnusedHi;
			logic [3:0]  fixPal;      // Bits 19..16 like the real chip
			logic [15:0] fixUnusedLo;
		} fix;
		logic [pBusWidth-1:0] raw;     // Plain view for driving the bus
	} pBusWord;

endpackage

// ==== logic/spriteWriter.sv ====
`timescale 1ns/100ps

module spriteWriter #(
	parameter int lineLength = 64               // Pixels per line, even
) (
	input  logic                            CLK_SPR_PAL,
	input  logic                            rstN,
	input  neoVideoPkg::pBusWord            pBus,
	input  logic                            attrLoad,     // Latch palette and X
	input  logic                            pixWrite,     // One pixel pair per strobe
	input  logic [3:0]                      gad,          // Even pixel
	input  logic [3:0]                      gbd,          // Odd pixel
	output logic                            wrEvenEn,
	output logic                            wrOddEn,
	output logic [7:0]                      wrPairAddr,
	output logic [neoVideoPkg::lbWord-1:0]  wrEvenData,
	output logic [neoVideoPkg::lbWord-1:0]  wrOddData
);
	import neoVideoPkg::*;

	// Number of even/odd pairs on one line
	localparam int pairCount = lineLength / 2;
	localparam logic [7:0] pairLimit = 8'(pairCount);

	logic [7:0] sprPal;        // Palette of the sprite being drawn
	logic [7:0] pairAddr;      // Next pair to write
	logic       pairInLine;    // Pair lies inside the visible line
	logic       evenOpaque;
	logic       oddOpaque;
	logic [lbWord-1:0] evenEntry;
	logic [lbWord-1:0] oddEntry;

	// Palette only shows on the bus with attrLoad, so hold it here
	always_ff @(posedge CLK_SPR_PAL)
	begin
		if (attrLoad)
			sprPal <= pBus.spr.sprPal;
	end

	// Pair counter
	// Loaded from X/2, X LSB dropped since pairs start on even pixels
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
			pairAddr <= '0;
		else if (attrLoad)
			pairAddr <= {1'b0, pBus.spr.sprX[7:1]};
		else if (pixWrite && (pairAddr != 8'hff))
			pairAddr <= pairAddr + 8'd1;    // Stop at top, avoids wrapping back in-line
	end

	// Right edge clip
	assign pairInLine = (pairAddr < pairLimit);

	// Colour 0 is transparent
	assign evenOpaque = |gad;
	assign oddOpaque  = |gbd;

	// Palette above the nibble
	assign evenEntry = {sprPal, gad};
	assign oddEntry  = {sprPal, gbd};

	// Enables follow the strobe in the same cycle
	// Halves are independent, so a half-transparent pair still writes the other half
	assign wrEvenEn = pixWrite & pairInLine & evenOpaque;
	assign wrOddEn  = pixWrite & pairInLine & oddOpaque;

	assign wrPairAddr = pairAddr;
	assign wrEvenData = evenEntry;
	assign wrOddData  = oddEntry;

	// Writes are only taken by the buffer on the enabled edge
	// Data lines may carry junk otherwise

	// Sequence per sprite slice:
	//   attrLoad      -> palette, pair = X/2
	//   pixWrite x N  -> pairs X/2 .. X/2+N-1
	// Pairs past the line end keep counting but never write

	// attrLoad and pixWrite never overlap, attrLoad wins anyway

endmodule

// ==== logic/lineBuffer.sv ====
`timescale 1ns/100ps

module lineBuffer #(
	parameter int lineLength = 64              // Even, at most 256
) (
	input  logic                            CLK_SPR_PAL,
	input  logic                            rstN,
	input  logic                            wrEvenEn,
	input  logic                            wrOddEn,
	input  logic [7:0]                      wrPairAddr,
	input  logic [neoVideoPkg::lbWord-1:0]  wrEvenData,
	input  logic [neoVideoPkg::lbWord-1:0]  wrOddData,
	input  logic                            lineStart,     // Bank swap and read restart
	output logic [neoVideoPkg::lbWord-1:0]  rdData,
	output logic                            rdOdd,
	output logic                            rdValid
);
	import neoVideoPkg::*;

	localparam int pairCount = lineLength / 2;
	localparam int pairW = $clog2(pairCount);
	localparam logic [7:0] lastPix = 8'(lineLength - 1);

	logic       bankSel;       // 0: render A, display B
	logic       startD;        // lineStart one clock later
	logic       rdActive;      // Line read-out running
	logic [7:0] rdCnt;         // Pixel being read
	logic       rdFire;
	logic [1:0] rdSel;         // {bank, odd} of display half
	logic [lbWord-1:0] rdWord [4];

	// No read on the restart clock
	// Keeps a stale address from clearing the freshly swapped bank
	assign rdFire = rdActive & ~startD;

	// Display bank is the one not rendered
	assign rdSel = {~bankSel, rdCnt[0]};

	// Bank flip, read counter, valid flag
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
		begin
			bankSel  <= 1'b0;
			startD   <= 1'b0;
			rdActive <= 1'b0;
			rdCnt    <= '0;
			rdOdd    <= 1'b0;
			rdValid  <= 1'b0;
		end
		else
		begin
			startD  <= lineStart;
			rdValid <= rdFire;
			if (lineStart)
				bankSel <= ~bankSel;     // Writes after this edge go to the other bank
			if (startD)
			begin
				rdCnt    <= '0;          // Also covers an early restart
				rdActive <= 1'b1;
			end
			else if (rdFire)
			begin
				rdOdd <= rdCnt[0];
				rdCnt <= rdCnt + 8'd1;
				if (rdCnt == lastPix)
					rdActive <= 1'b0;     // Last pixel of the line
			end
		end
	end

	// Output entry, only meaningful with rdValid
	always_ff @(posedge CLK_SPR_PAL)
	begin
		if (rdFire)
			rdData <= rdWord[rdSel];
	end

	// Four halves: 0 even A, 1 odd A, 2 even B, 3 odd B
	for (genvar i = 0; i < 4; i++)
	begin : gArray
		localparam logic arrBank = 1'(i >> 1);
		localparam logic arrOdd  = 1'(i & 1);

		logic [lbWord-1:0] mem [pairCount];
		logic              isRender;
		logic              wrHit;        // Sprite pixel write
		logic              clrHit;       // Clear behind the read

		assign isRender = (arrBank == bankSel);
		assign wrHit    = isRender & (arrOdd ? wrOddEn : wrEvenEn);
		assign clrHit   = ~isRender & rdFire & (rdCnt[0] == arrOdd);

		// Same location that the read counter points at
		assign rdWord[i] = mem[rdCnt[pairW:1]];

		// Buffer comes up empty; read-then-clear keeps it that way per line
		always_ff @(posedge CLK_SPR_PAL or negedge rstN)
		begin
			if (!rstN)
			begin
				for (int j = 0; j < pairCount; j++)
					mem[j] <= lbCleared;
			end
			else if (wrHit)
				mem[wrPairAddr[pairW-1:0]] <= arrOdd ? wrOddData : wrEvenData;
			else if (clrHit)
				mem[rdCnt[pairW:1]] <= lbCleared;   // Stands in for the pull-ups
		end
	end

	// Pixel k: address in cycle after t0+1+k, data and valid at t0+2+k
	// Render and display never share an array, so write and clear never collide

endmodule

// ==== logic/pixelMixer.sv ====
`timescale 1ns/100ps

module pixelMixer (
	input  logic                            CLK_SPR_PAL,
	input  logic                            rstN,
	input  neoVideoPkg::pBusWord            pBus,
	input  logic                            fixLoad,     // Latch fix palette
	input  logic [7:0]                      fixD,        // Two fix pixels per byte
	input  logic                            chbl,        // Blanking
	input  logic [neoVideoPkg::lbWord-1:0]  rdData,
	input  logic                            rdOdd,
	input  logic                            rdValid,
	output logic [11:0]                     pa,          // Palette RAM address
	output logic                            paValid
);
	import neoVideoPkg::*;

	logic [3:0]        fixPal;
	logic [7:0]        fixA;         // First delay stage
	logic [7:0]        fixB;         // Lined up with rdData
	logic              chblA;
	logic              chblB;
	logic [3:0]        fixColor;
	logic              fixOpaque;
	logic [lbWord-1:0] paNext;

	// Fix palette from bits 19..16 of the bus
	always_ff @(posedge CLK_SPR_PAL)
	begin
		if (fixLoad)
			fixPal <= pBus.fix.fixPal;
	end

	// Two stages to meet the line buffer read latency
	always_ff @(posedge CLK_SPR_PAL)
	begin
		fixA <= fixD;
		fixB <= fixA;
	end

	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
		begin
			chblA <= 1'b0;
			chblB <= 1'b0;
		end
		else
		begin
			chblA <= chbl;
			chblB <= chblA;
		end
	end

	// Odd pixels on bits 7/5/3/1, even ones on 6/4/2/0
	assign fixColor = rdOdd ? {fixB[7], fixB[5], fixB[3], fixB[1]}
	                        : {fixB[6], fixB[4], fixB[2], fixB[0]};
	assign fixOpaque = |fixColor;

	// Priority: blanking, then opaque fix, then sprite entry
	always_comb
	begin
		if (chblB)
			paNext = '0;
		else if (fixOpaque)
			paNext = {4'b0000, fixPal, fixColor};   // Fix palettes sit in the low 16
		else
			paNext = rdData;                         // All ones when nothing drawn
	end

	// Address register, held between lines
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
		begin
			pa      <= '0;
			paValid <= 1'b0;
		end
		else
		begin
			paValid <= rdValid;
			if (rdValid)
				pa <= paNext;
		end
	end

endmodule

// ==== logic/neoB1Video.sv ====
`timescale 1ns/100ps

module neoB1Video #(
	parameter int lineLength = 64               // Pixels per line
) (
	input  logic                  CLK_SPR_PAL,
	input  logic                  rstN,
	input  neoVideoPkg::pBusWord  pBus,
	input  logic                  attrLoad,
	input  logic                  pixWrite,
	input  logic [3:0]            gad,
	input  logic [3:0]            gbd,
	input  logic                  lineStart,
	input  logic                  fixLoad,
	input  logic [7:0]            fixD,
	input  logic                  chbl,
	output logic [11:0]           pa,
	output logic                  paValid
);
	import neoVideoPkg::*;

	// Writer to buffer
	logic              wrEvenEn;
	logic              wrOddEn;
	logic [7:0]        wrPairAddr;
	logic [lbWord-1:0] wrEvenData;
	logic [lbWord-1:0] wrOddData;

	// Buffer to mixer
	logic [lbWord-1:0] rdData;
	logic              rdOdd;
	logic              rdValid;

	// Sprite pixels into the render bank
	spriteWriter #(
		.lineLength (lineLength)
	) i_spriteWriter (
		.CLK_SPR_PAL (CLK_SPR_PAL),
		.rstN        (rstN),
		.pBus        (pBus),
		.attrLoad    (attrLoad),
		.pixWrite    (pixWrite),
		.gad         (gad),
		.gbd         (gbd),
		.wrEvenEn    (wrEvenEn),
		.wrOddEn     (wrOddEn),
		.wrPairAddr  (wrPairAddr),
		.wrEvenData  (wrEvenData),
		.wrOddData   (wrOddData)
	);

	// Ping-pong banks, display side read and cleared
	lineBuffer #(
		.lineLength (lineLength)
	) i_lineBuffer (
		.CLK_SPR_PAL (CLK_SPR_PAL),
		.rstN        (rstN),
		.wrEvenEn    (wrEvenEn),
		.wrOddEn     (wrOddEn),
		.wrPairAddr  (wrPairAddr),
		.wrEvenData  (wrEvenData),
		.wrOddData   (wrOddData),
		.lineStart   (lineStart),
		.rdData      (rdData),
		.rdOdd       (rdOdd),
		.rdValid     (rdValid)
	);

	// Fix over sprite, blanking, PA register
	// Three clocks from lineStart to pixel 0 on pa
	pixelMixer i_pixelMixer (
		.CLK_SPR_PAL (CLK_SPR_PAL),
		.rstN        (rstN),
		.pBus        (pBus),
		.fixLoad     (fixLoad),
		.fixD        (fixD),
		.chbl        (chbl),
		.rdData      (rdData),
		.rdOdd       (rdOdd),
		.rdValid     (rdValid),
		.pa          (pa),
		.paValid     (paValid)
	);

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/100ps

module clockGen #(
	parameter realtime halfPeriod = 50.0,     // 100 ns pixel clock
	parameter int      resetCycles = 16
) (
	output logic CLK_SPR_PAL,
	output logic rstN
);

	initial
	begin
		CLK_SPR_PAL = 1'b0;
		forever #(halfPeriod) CLK_SPR_PAL = ~CLK_SPR_PAL;
	end

	// Release on a falling edge, clear of the rising one
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge CLK_SPR_PAL);
		@(negedge CLK_SPR_PAL);
		rstN = 1'b1;
	end

endmodule

// ==== sim/neoB1VideoChecker.sv ====
`timescale 1ns/100ps

module neoB1VideoChecker #(
	parameter int lineLength = 64
) (
	input logic        CLK_SPR_PAL,
	input logic        rstN,
	input logic        chbl,
	input logic [11:0] pa,
	input logic        paValid,
	input logic        wrEvenEn,
	input logic        wrOddEn,
	input logic [7:0]  wrPairAddr
);

	localparam logic [7:0] pairLimit = 8'(lineLength / 2);

	// Output stays quiet while reset is held
	resetQuiet: assert property (@(posedge CLK_SPR_PAL) !rstN |-> !paValid)
		else $error("paValid high during reset");

	// Blank flag sampled three edges back lines up with the current pa
	blankZero: assert property (@(posedge CLK_SPR_PAL) disable iff (!rstN)
		(paValid && $past(chbl, 3)) |-> (pa == 12'h000))
		else $error("pa not zero while blanked");

	// No write outside the visible line
	clipWrite: assert property (@(posedge CLK_SPR_PAL) disable iff (!rstN)
		(wrEvenEn || wrOddEn) |-> (wrPairAddr < pairLimit))
		else $error("line buffer write past line end");

endmodule

bind neoB1Video neoB1VideoChecker #(
	.lineLength (lineLength)
) i_neoB1VideoChecker (
	.CLK_SPR_PAL (CLK_SPR_PAL),
	.rstN        (rstN),
	.chbl        (chbl),
	.pa          (pa),
	.paValid     (paValid),
	.wrEvenEn    (wrEvenEn),
	.wrOddEn     (wrOddEn),
	.wrPairAddr  (wrPairAddr)
);

// ==== sim/neoB1VideoTb.sv ====
`timescale 1ns/100ps

module neoB1VideoTb;
	import neoVideoPkg::*;

	localparam int lineLen = 64;
	localparam int numLines = 6;

	typedef struct {
		string      name;
		logic [7:0] pal1;
		logic [7:0] x1;
		int         n1;           // Pairs of first sprite
		logic [7:0] pal2;
		logic [7:0] x2;
		int         n2;           // 0 means no second sprite
		bit         holes;        // Extra transparent nibbles
		logic [3:0] fixPal;
		int         fixLo;        // Fix pair range
		int         fixHi;
		logic [7:0] fixA;         // Byte on even pairs
		logic [7:0] fixB;         // Byte on odd pairs
		int         blankLo;      // Blanked pixel range
		int         blankHi;
	} lineEntry;

	logic        CLK_SPR_PAL;
	logic        rstN;
	pBusWord     pBus;
	logic        attrLoad;
	logic        pixWrite;
	logic [3:0]  gad;
	logic [3:0]  gbd;
	logic        lineStart;
	logic        fixLoad;
	logic [7:0]  fixD;
	logic        chbl;
	logic [11:0] pa;
	logic        paValid;

	lineEntry    table_ [numLines];
	logic [11:0] expBuf [numLines][lineLen];   // Reference line buffer per line
	integer      seed = 32'h8d9dbe8d;
	int          errors = 0;
	int          passCnt = 0;
	int          failCnt = 0;
	bit          timedOut = 0;
	int          rstWait;

	clockGen i_clockGen (
		.CLK_SPR_PAL (CLK_SPR_PAL),
		.rstN        (rstN)
	);

	neoB1Video #(
		.lineLength (lineLen)
	) i_neoB1Video (
		.CLK_SPR_PAL (CLK_SPR_PAL),
		.rstN        (rstN),
		.pBus        (pBus),
		.attrLoad    (attrLoad),
		.pixWrite    (pixWrite),
		.gad         (gad),
		.gbd         (gbd),
		.lineStart   (lineStart),
		.fixLoad     (fixLoad),
		.fixD        (fixD),
		.chbl        (chbl),
		.pa          (pa),
		.paValid     (paValid)
	);

	task automatic addEntry(input int i, input string name, input logic [7:0] pal1,
		input logic [7:0] x1, input int n1, input logic [7:0] pal2, input logic [7:0] x2,
		input int n2, input bit holes, input logic [3:0] fixPal, input int fixLo,
		input int fixHi, input logic [7:0] fixA, input logic [7:0] fixB,
		input int blankLo, input int blankHi);
		table_[i] = '{name, pal1, x1, n1, pal2, x2, n2, holes, fixPal, fixLo, fixHi,
			fixA, fixB, blankLo, blankHi};
		for (int k = 0; k < lineLen; k++)
			expBuf[i][k] = 12'hfff;      // Empty bank reads all ones
	endtask

	function automatic logic [7:0] fixByteFor(input int i, input int pair);
		if (pair >= table_[i].fixLo && pair <= table_[i].fixHi)
			return (pair % 2 == 1) ? table_[i].fixB : table_[i].fixA;
		return 8'h00;
	endfunction

	function automatic bit isBlank(input int i, input int k);
		return (k >= table_[i].blankLo) && (k <= table_[i].blankHi);
	endfunction

	// Blank, then opaque fix nibble, then sprite entry
	function automatic logic [11:0] expectedPa(input int i, input int k);
		logic [7:0] fb;
		logic [3:0] nib;
		fb = fixByteFor(i, k / 2);
		if (isBlank(i, k))
			return 12'h000;
		nib = (k % 2 == 1) ? {fb[7], fb[5], fb[3], fb[1]} : {fb[6], fb[4], fb[2], fb[0]};
		if (nib != 4'h0)
			return {4'h0, table_[i].fixPal, nib};
		return expBuf[i][k];
	endfunction

	// Attribute load then one pair per clock, reference updated alongside
	task automatic renderSprite(input int i, input logic [7:0] pal, input logic [7:0] x,
		input int n);
		logic [3:0] ev;
		logic [3:0] od;
		int pair;
		@(negedge CLK_SPR_PAL);
		pBus.raw = {pal, x, 8'h00};
		attrLoad = 1'b1;
		@(negedge CLK_SPR_PAL);
		attrLoad = 1'b0;
		for (int p = 0; p < n; p++)
		begin
			ev = 4'($random(seed));
			od = 4'($random(seed));
			if (table_[i].holes && (($random(seed) & 3) == 0))
				ev = 4'h0;
			if (table_[i].holes && (($random(seed) & 3) == 0))
				od = 4'h0;
			pixWrite = 1'b1;
			gad = ev;
			gbd = od;
			pair = int'(x[7:1]) + p;
			if (pair < lineLen / 2)          // Clipped past the line end
			begin
				if (ev != 4'h0)
					expBuf[i][2 * pair] = {pal, ev};
				if (od != 4'h0)
					expBuf[i][2 * pair + 1] = {pal, od};
			end
			@(negedge CLK_SPR_PAL);
		end
		pixWrite = 1'b0;
		gad = 4'h0;
		gbd = 4'h0;
	endtask

	task automatic renderEntry(input int i);
		renderSprite(i, table_[i].pal1, table_[i].x1, table_[i].n1);
		if (table_[i].n2 > 0)
			renderSprite(i, table_[i].pal2, table_[i].x2, table_[i].n2);
	endtask

	task automatic loadFix(input int i);
		@(negedge CLK_SPR_PAL);
		pBus.raw = {4'h0, table_[i].fixPal, 16'h0000};
		fixLoad = 1'b1;
		@(negedge CLK_SPR_PAL);
		fixLoad = 1'b0;
	endtask

	task automatic pulseLine();
		@(negedge CLK_SPR_PAL);
		lineStart = 1'b1;
		@(negedge CLK_SPR_PAL);
		lineStart = 1'b0;
	endtask

	// Pixel k sampled on edge t0+1+k
	task automatic driveFix(input int i);
		for (int k = 0; k < lineLen; k++)
		begin
			fixD = fixByteFor(i, k / 2);
			chbl = isBlank(i, k);
			@(negedge CLK_SPR_PAL);
		end
		fixD = 8'h00;
		chbl = 1'b0;
	endtask

	task automatic collectLine(input int i);
		int waitCnt;
		int bad;
		logic [11:0] want;
		waitCnt = 0;
		bad = 0;
		while (!paValid && waitCnt < 20)
		begin
			@(negedge CLK_SPR_PAL);
			waitCnt++;
		end
		if (!paValid)
		begin
			$display("Timeout: no paValid for line %s", table_[i].name);
			timedOut = 1;
			bad++;
		end
		else
		begin
			for (int k = 0; k < lineLen; k++)
			begin
				if (!paValid)
				begin
					$display("Line %s: paValid dropped after %0d pixels", table_[i].name, k);
					bad++;
					break;
				end
				want = expectedPa(i, k);
				if (pa !== want)
				begin
					$display("Error %s pixel %0d: expected %h, actual %h",
						table_[i].name, k, want, pa);
					bad++;
				end
				@(negedge CLK_SPR_PAL);
			end
			if (paValid)
			begin
				$display("Line %s: paValid still high after %0d pixels", table_[i].name, lineLen);
				bad++;
			end
		end
		errors += bad;
		if (bad == 0)
			passCnt++;
		else
			failCnt++;
		$display("Line %-14s %s (%0d mismatches)", table_[i].name, (bad == 0) ? "ok" : "bad", bad);
	endtask

	initial
	begin
		pBus.raw = '0;
		attrLoad = 1'b0;
		pixWrite = 1'b0;
		gad = 4'h0;
		gbd = 4'h0;
		lineStart = 1'b0;
		fixLoad = 1'b0;
		fixD = 8'h00;
		chbl = 1'b0;

		//        name            pal1   x1   n1 pal2   x2  n2 hol fpal lo hi fixA   fixB  blank
		addEntry(0, "spritePlace",  8'h21, 8'd10, 6, 8'h00, 8'd0,  0, 0, 4'h3, 1, 0, 8'h00, 8'h00, 1, 0);
		addEntry(1, "transparency", 8'h35, 8'd4,  8, 8'h4a, 8'd8,  6, 1, 4'h3, 1, 0, 8'h00, 8'h00, 1, 0);
		addEntry(2, "fixPriority",  8'h12, 8'd0, 16, 8'h00, 8'd0,  0, 0, 4'h9, 2, 9, 8'ha5, 8'h50, 1, 0);
		addEntry(3, "blanking",     8'h5c, 8'd20,10, 8'h00, 8'd0,  0, 0, 4'h6, 10, 13, 8'h0f, 8'hf0, 24, 35);
		addEntry(4, "edgeClip",     8'h77, 8'd56, 8, 8'h66, 8'd63, 3, 0, 4'h1, 1, 0, 8'h00, 8'h00, 1, 0);
		addEntry(5, "clearCheck",   8'h00, 8'd0,  0, 8'h00, 8'd0,  0, 0, 4'h2, 1, 0, 8'h00, 8'h00, 1, 0);

		rstWait = 0;
		while (!rstN && rstWait < 40)
		begin
			@(negedge CLK_SPR_PAL);
			rstWait++;
		end
		if (!rstN)
		begin
			$display("Timeout: reset never released");
			timedOut = 1;
		end
		else
		begin
			renderEntry(0);
			for (int i = 0; i < numLines; i++)
			begin
				loadFix(i);
				pulseLine();
				// Display line i while rendering line i+1 into the other bank
				fork
					driveFix(i);
					begin
						if (i + 1 < numLines)
							renderEntry(i + 1);
					end
					collectLine(i);
				join
				if (timedOut)
					break;
			end
		end

		$display("Lines run %0d, passed %0d, failed %0d, pixel errors %0d",
			passCnt + failCnt, passCnt, failCnt, errors);
		if (errors == 0 && failCnt == 0 && !timedOut)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== neoB1Video.f ====
logic/neoVideoPkg.sv
logic/spriteWriter.sv
logic/lineBuffer.sv
logic/pixelMixer.sv
logic/neoB1Video.sv
sim/clockGen.sv
sim/neoB1VideoChecker.sv
sim/neoB1VideoTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the line buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f neoB1Video.f \
	--top-module neoB1VideoTb -o simv > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No pass result in sim.log"; exit 1; }
exit 0
